// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_trace
FILELIST   := all.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
rtl/trace_pkg.sv
rtl/trace_capture.sv
rtl/trace_fifo.sv
rtl/trace_record_seq.sv
rtl/trace_top.sv
tests/tb_trace.sv

// ==== rtl/trace_capture.sv ====
//----------------------------------------
// Trace capture
// Stamps each update cycle, classifies the
// event and snapshots PC and CSR words
//----------------------------------------

`timescale 1ns/100ps

module trace_capture import trace_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pc_update_en_i,
    input  logic [XLEN-1:0]   pc_update_i,
    input  logic [XLEN-1:0]   instr_i,
    input  logic              gpr_wr_en_i,
    input  logic [GPR_AW-1:0] gpr_wr_addr_i,
    input  logic [XLEN-1:0]   gpr_wr_data_i,
    input  csr_bits_s         csr_i,
    input  logic              e_exc_i,
    input  logic              e_irq_i,
    input  logic              e_wake_i,
    output logic              push_o,
    output trace_entry_s      entry_o
);

    logic               update;
    logic [STAMP_W-1:0] cycle_cnt;
    logic [XLEN-1:0]    npc_q;
    logic               push_q;
    trace_entry_s       entry_q;
    trace_event_e       event_d;
    logic [XLEN-1:0]    mstatus_w;
    logic [XLEN-1:0]    mepc_w;
    logic [XLEN-1:0]    mcause_w;
    logic [XLEN-1:0]    mip_w;
    logic [XLEN-1:0]    mie_w;

    assign update = pc_update_en_i | gpr_wr_en_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;  // Zero in first cycle out of reset
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Exception wins over interrupt, interrupt over wake
    always_comb begin
        if (e_exc_i) begin
            event_d = EV_EXC;
        end else if (e_irq_i) begin
            event_d = EV_IRQ;
        end else if (e_wake_i) begin
            event_d = EV_WAKE;
        end else begin
            event_d = EV_NONE;
        end
    end

    //----------------------------------------
    // CSR word packing
    //----------------------------------------
    always_comb begin
        mstatus_w = '0;
        mstatus_w[MSTATUS_MIE_BIT]  = csr_i.mstatus_mie;
        mstatus_w[MSTATUS_MPIE_BIT] = csr_i.mstatus_mpie;
        mstatus_w[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB] = MSTATUS_MPP_VAL;

        mepc_w = {csr_i.mepc, 1'b0};

        mcause_w = '0;
        mcause_w[XLEN-1]   = csr_i.mcause_irq;
        mcause_w[EC_W-1:0] = csr_i.mcause_ec;

        mip_w = '0;
        mip_w[MI_MS_BIT] = csr_i.mip_msip;
        mip_w[MI_MT_BIT] = csr_i.mip_mtip;
        mip_w[MI_ME_BIT] = csr_i.mip_meip;

        mie_w = '0;
        mie_w[MI_MS_BIT] = csr_i.mie_msie;
        mie_w[MI_MT_BIT] = csr_i.mie_mtie;
        mie_w[MI_ME_BIT] = csr_i.mie_meie;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push_q <= 1'b0;
            npc_q  <= '0;
        end else begin
            push_q <= update;
            if (update) begin
                npc_q <= pc_update_i;
            end
        end
    end

    // Entry payload held until the next update
    always_ff @(posedge clk) begin
        if (update) begin
            entry_q.stamp    <= cycle_cnt;
            entry_q.ev       <= event_d;
            entry_q.pc       <= npc_q;        // PC chains from the last npc
            entry_q.instr    <= instr_i;
            entry_q.npc      <= pc_update_i;
            entry_q.gpr_wr   <= gpr_wr_en_i;
            entry_q.gpr_addr <= gpr_wr_addr_i;
            entry_q.gpr_data <= gpr_wr_data_i;
            entry_q.mstatus  <= mstatus_w;
            entry_q.mepc     <= mepc_w;
            entry_q.mcause   <= mcause_w;
            entry_q.mtval    <= csr_i.mtval;
            entry_q.mip      <= mip_w;
            entry_q.mie      <= mie_w;
        end
    end

    assign push_o  = push_q;
    assign entry_o = entry_q;

    // A pushed entry carries the stamp of its update cycle
    a_push_stamp : assert property (@(posedge clk) disable iff (!rst_n)
        push_o |-> (entry_o.stamp == cycle_cnt - 1'b1));

endmodule : trace_capture

// ==== rtl/trace_fifo.sv ====
//----------------------------------------
// Trace entry FIFO
// Circular buffer, drops on full and keeps
// a sticky overflow flag
//----------------------------------------

`timescale 1ns/100ps

module trace_fifo import trace_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         push_i,
    input  trace_entry_s entry_i,
    input  logic         pop_i,
    output logic         not_empty_o,
    output trace_entry_s head_o,
    output logic         overflow_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    trace_entry_s     mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;
    logic             overflow_q;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign wr_en = push_i && !full;
    assign rd_en = pop_i && (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
            if (push_i && full) begin
                overflow_q <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    assign not_empty_o = (count != '0);
    assign head_o      = mem[rd_ptr];
    assign overflow_o  = overflow_q;

    // The sequencer must only pop a live entry
    a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> not_empty_o);

    a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(FIFO_DEPTH));

endmodule : trace_fifo

// ==== rtl/trace_pkg.sv ====
//----------------------------------------
// Trace package
// Widths, CSR bit offsets and the entry
// types shared by the trace generator
//----------------------------------------

package trace_pkg;

    // Widths
    localparam int XLEN    = 32;
    localparam int GPR_AW  = 5;
    localparam int EC_W    = 4;
    localparam int STAMP_W = 32;

    // mstatus fields
    localparam int         MSTATUS_MIE_BIT  = 3;
    localparam int         MSTATUS_MPIE_BIT = 7;
    localparam int         MSTATUS_MPP_LSB  = 11;
    localparam logic [1:0] MSTATUS_MPP_VAL  = 2'b11;  // Machine mode only

    // Same offsets in mie and mip
    localparam int MI_MS_BIT = 3;
    localparam int MI_MT_BIT = 7;
    localparam int MI_ME_BIT = 11;

    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_EXC  = 2'd1,
        EV_IRQ  = 2'd2,
        EV_WAKE = 2'd3
    } trace_event_e;

    // What a record carries
    typedef enum logic [2:0] {
        REG_NONE    = 3'd0,
        REG_GPR     = 3'd1,
        REG_MSTATUS = 3'd2,
        REG_MEPC    = 3'd3,
        REG_MCAUSE  = 3'd4,
        REG_MTVAL   = 3'd5,
        REG_MIP     = 3'd6,
        REG_MIE     = 3'd7
    } trace_reg_e;

    // Raw CSR bits from the core
    typedef struct packed {
        logic            mstatus_mie;
        logic            mstatus_mpie;
        logic            mie_meie;
        logic            mie_mtie;
        logic            mie_msie;
        logic            mip_meip;
        logic            mip_mtip;
        logic            mip_msip;
        logic [XLEN-1:1] mepc;
        logic            mcause_irq;
        logic [EC_W-1:0] mcause_ec;
        logic [XLEN-1:0] mtval;
    } csr_bits_s;

    typedef struct packed {
        logic [STAMP_W-1:0] stamp;
        trace_event_e       ev;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    instr;
        logic [XLEN-1:0]    npc;
        logic               gpr_wr;
        logic [GPR_AW-1:0]  gpr_addr;
        logic [XLEN-1:0]    gpr_data;
        logic [XLEN-1:0]    mstatus;
        logic [XLEN-1:0]    mepc;
        logic [XLEN-1:0]    mcause;
        logic [XLEN-1:0]    mtval;
        logic [XLEN-1:0]    mip;
        logic [XLEN-1:0]    mie;
    } trace_entry_s;

endpackage : trace_pkg

// ==== rtl/trace_record_seq.sv ====
//----------------------------------------
// Trace record sequencer
// Expands the head entry into its records,
// one per clock, and pops it when done
//----------------------------------------

`timescale 1ns/100ps

module trace_record_seq import trace_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               not_empty_i,
    input  trace_entry_s       head_i,
    output logic               pop_o,
    output logic               rec_valid_o,
    output logic [STAMP_W-1:0] rec_stamp_o,
    output trace_event_e       rec_event_o,
    output logic [XLEN-1:0]    rec_pc_o,
    output logic [XLEN-1:0]    rec_instr_o,
    output logic [XLEN-1:0]    rec_npc_o,
    output trace_reg_e         rec_reg_o,
    output logic [GPR_AW-1:0]  rec_gpr_addr_o,
    output logic [XLEN-1:0]    rec_value_o
);

    // State is the record being emitted
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_GPR,
        ST_NONE,
        ST_MSTATUS,
        ST_MEPC,
        ST_MCAUSE,
        ST_MTVAL,
        ST_MIP,
        ST_MIE
    } seq_state_e;

    seq_state_e state_q;
    seq_state_e state_d;
    seq_state_e first_st;
    logic       last_rec;

    //----------------------------------------
    // First record of the head entry
    //----------------------------------------
    always_comb begin
        case (head_i.ev)
            EV_EXC, EV_IRQ: begin
                first_st = ST_MSTATUS;
            end
            EV_WAKE: begin
                first_st = (|(head_i.mip & head_i.mie)) ? ST_MIP : ST_NONE;
            end
            default: begin
                first_st = (head_i.gpr_wr && head_i.gpr_addr != '0) ? ST_GPR : ST_NONE;
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (not_empty_i) state_d = first_st;
            ST_MSTATUS: state_d = ST_MEPC;
            ST_MEPC:    state_d = ST_MCAUSE;
            ST_MCAUSE:  state_d = ST_MTVAL;
            ST_MIP:     state_d = ST_MIE;
            default:    state_d = ST_IDLE;  // Last record of an entry
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign last_rec = (state_q == ST_GPR) || (state_q == ST_NONE) ||
                      (state_q == ST_MTVAL) || (state_q == ST_MIE);

    assign rec_valid_o = (state_q != ST_IDLE);
    assign pop_o       = last_rec;

    // Common fields come straight from the head
    assign rec_stamp_o = head_i.stamp;
    assign rec_event_o = head_i.ev;
    assign rec_pc_o    = head_i.pc;
    assign rec_instr_o = head_i.instr;
    assign rec_npc_o   = head_i.npc;

    //----------------------------------------
    // Per-record register and value
    //----------------------------------------
    always_comb begin
        rec_reg_o      = REG_NONE;
        rec_gpr_addr_o = '0;
        rec_value_o    = '0;
        case (state_q)
            ST_GPR: begin
                rec_reg_o      = REG_GPR;
                rec_gpr_addr_o = head_i.gpr_addr;
                rec_value_o    = head_i.gpr_data;
            end
            ST_MSTATUS: begin
                rec_reg_o   = REG_MSTATUS;
                rec_value_o = head_i.mstatus;
            end
            ST_MEPC: begin
                rec_reg_o   = REG_MEPC;
                rec_value_o = head_i.mepc;
            end
            ST_MCAUSE: begin
                rec_reg_o   = REG_MCAUSE;
                rec_value_o = head_i.mcause;
            end
            ST_MTVAL: begin
                rec_reg_o   = REG_MTVAL;
                rec_value_o = head_i.mtval;
            end
            ST_MIP: begin
                rec_reg_o   = REG_MIP;
                rec_value_o = head_i.mip;
            end
            ST_MIE: begin
                rec_reg_o   = REG_MIE;
                rec_value_o = head_i.mie;
            end
            default: ;  // Idle and empty record
        endcase
    end

    // Records only come from an entry the FIFO still holds
    a_record_live : assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid_o |-> not_empty_i);

endmodule : trace_record_seq

// ==== rtl/trace_top.sv ====
//----------------------------------------
// Trace generator top level
// Capture, entry FIFO and record sequencer
//----------------------------------------

`timescale 1ns/100ps

module trace_top import trace_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pc_update_en_i,
    input  logic [XLEN-1:0]    pc_update_i,
    input  logic [XLEN-1:0]    instr_i,
    input  logic               gpr_wr_en_i,
    input  logic [GPR_AW-1:0]  gpr_wr_addr_i,
    input  logic [XLEN-1:0]    gpr_wr_data_i,
    input  logic               mstatus_mie_i,
    input  logic               mstatus_mpie_i,
    input  logic               mie_meie_i,
    input  logic               mie_mtie_i,
    input  logic               mie_msie_i,
    input  logic               mip_meip_i,
    input  logic               mip_mtip_i,
    input  logic               mip_msip_i,
    input  logic [XLEN-1:1]    mepc_i,
    input  logic               mcause_irq_i,
    input  logic [EC_W-1:0]    mcause_ec_i,
    input  logic [XLEN-1:0]    mtval_i,
    input  logic               e_exc_i,
    input  logic               e_irq_i,
    input  logic               e_wake_i,
    output logic               rec_valid_o,
    output logic [STAMP_W-1:0] rec_stamp_o,
    output trace_event_e       rec_event_o,
    output logic [XLEN-1:0]    rec_pc_o,
    output logic [XLEN-1:0]    rec_instr_o,
    output logic [XLEN-1:0]    rec_npc_o,
    output trace_reg_e         rec_reg_o,
    output logic [GPR_AW-1:0]  rec_gpr_addr_o,
    output logic [XLEN-1:0]    rec_value_o,
    output logic               overflow_o
);

    csr_bits_s    csr_bits;
    logic         push;
    trace_entry_s push_entry;
    logic         pop;
    logic         not_empty;
    trace_entry_s head;

    // Group the loose CSR inputs
    assign csr_bits = '{
        mstatus_mie:  mstatus_mie_i,
        mstatus_mpie: mstatus_mpie_i,
        mie_meie:     mie_meie_i,
        mie_mtie:     mie_mtie_i,
        mie_msie:     mie_msie_i,
        mip_meip:     mip_meip_i,
        mip_mtip:     mip_mtip_i,
        mip_msip:     mip_msip_i,
        mepc:         mepc_i,
        mcause_irq:   mcause_irq_i,
        mcause_ec:    mcause_ec_i,
        mtval:        mtval_i
    };

    trace_capture capture_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_update_en_i (pc_update_en_i),
        .pc_update_i    (pc_update_i),
        .instr_i        (instr_i),
        .gpr_wr_en_i    (gpr_wr_en_i),
        .gpr_wr_addr_i  (gpr_wr_addr_i),
        .gpr_wr_data_i  (gpr_wr_data_i),
        .csr_i          (csr_bits),
        .e_exc_i        (e_exc_i),
        .e_irq_i        (e_irq_i),
        .e_wake_i       (e_wake_i),
        .push_o         (push),
        .entry_o        (push_entry)
    );

    trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .entry_i     (push_entry),
        .pop_i       (pop),
        .not_empty_o (not_empty),
        .head_o      (head),
        .overflow_o  (overflow_o)
    );

    trace_record_seq seq_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .not_empty_i    (not_empty),
        .head_i         (head),
        .pop_o          (pop),
        .rec_valid_o    (rec_valid_o),
        .rec_stamp_o    (rec_stamp_o),
        .rec_event_o    (rec_event_o),
        .rec_pc_o       (rec_pc_o),
        .rec_instr_o    (rec_instr_o),
        .rec_npc_o      (rec_npc_o),
        .rec_reg_o      (rec_reg_o),
        .rec_gpr_addr_o (rec_gpr_addr_o),
        .rec_value_o    (rec_value_o)
    );

endmodule : trace_top

// ==== tests/tb_trace.sv ====
//----------------------------------------
// Trace generator testbench
// Random retirement stimulus, reference
// record model and field-by-field checks
//----------------------------------------

`timescale 1ns/100ps

module tb_trace import trace_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CYCLES = 20;
    localparam int N_GPR        = 40;
    localparam int N_TRAP       = 30;
    localparam int N_WAKE       = 20;
    localparam int N_BURST      = 12;
    localparam int OVF_CYCLES   = 20;
    localparam int OVF_HOLD     = 40;
    // Worst case per single update and per burst, including the drain
    localparam int STIM_CYCLES  = 2 * (RESET_CYCLES + QUIET_CYCLES) + 10
                                + 10 * (N_GPR + N_TRAP + 2 * N_WAKE) + 20 * N_BURST
                                + OVF_CYCLES + 30 + OVF_HOLD;
    localparam int TIMEOUT      = 2 * STIM_CYCLES + 200;

    typedef struct packed {
        logic [31:0]  stamp;
        trace_event_e ev;
        logic [31:0]  pc;
        logic [31:0]  instr;
        logic [31:0]  npc;
        trace_reg_e   kind;
        logic [4:0]   addr;
        logic [31:0]  value;
    } exp_rec_t;

    logic clk;
    logic rst_n;
    logic pc_update_en_i;
    logic [31:0] pc_update_i;
    logic [31:0] instr_i;
    logic gpr_wr_en_i;
    logic [4:0] gpr_wr_addr_i;
    logic [31:0] gpr_wr_data_i;
    logic mstatus_mie_i;
    logic mstatus_mpie_i;
    logic mie_meie_i;
    logic mie_mtie_i;
    logic mie_msie_i;
    logic mip_meip_i;
    logic mip_mtip_i;
    logic mip_msip_i;
    logic [30:0] mepc_i;
    logic mcause_irq_i;
    logic [3:0] mcause_ec_i;
    logic [31:0] mtval_i;
    logic e_exc_i;
    logic e_irq_i;
    logic e_wake_i;

    logic         rec_valid;
    logic [31:0]  rec_stamp;
    trace_event_e rec_event;
    logic [31:0]  rec_pc;
    logic [31:0]  rec_instr;
    logic [31:0]  rec_npc;
    trace_reg_e   rec_reg;
    logic [4:0]   rec_gpr_addr;
    logic [31:0]  rec_value;
    logic         overflow;

    exp_rec_t    exp_q[$];
    exp_rec_t    front;
    logic [31:0] lfsr_q     = 32'hd852;
    logic [31:0] ref_cycle  = '0;
    logic [31:0] ref_npc    = '0;
    int          tb_cycle   = 0;
    logic        predict_en = 1'b1;
    logic        check_en   = 1'b0;

    trace_top #(
        .FIFO_DEPTH (4)
    ) trace_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_update_en_i (pc_update_en_i),
        .pc_update_i    (pc_update_i),
        .instr_i        (instr_i),
        .gpr_wr_en_i    (gpr_wr_en_i),
        .gpr_wr_addr_i  (gpr_wr_addr_i),
        .gpr_wr_data_i  (gpr_wr_data_i),
        .mstatus_mie_i  (mstatus_mie_i),
        .mstatus_mpie_i (mstatus_mpie_i),
        .mie_meie_i     (mie_meie_i),
        .mie_mtie_i     (mie_mtie_i),
        .mie_msie_i     (mie_msie_i),
        .mip_meip_i     (mip_meip_i),
        .mip_mtip_i     (mip_mtip_i),
        .mip_msip_i     (mip_msip_i),
        .mepc_i         (mepc_i),
        .mcause_irq_i   (mcause_irq_i),
        .mcause_ec_i    (mcause_ec_i),
        .mtval_i        (mtval_i),
        .e_exc_i        (e_exc_i),
        .e_irq_i        (e_irq_i),
        .e_wake_i       (e_wake_i),
        .rec_valid_o    (rec_valid),
        .rec_stamp_o    (rec_stamp),
        .rec_event_o    (rec_event),
        .rec_pc_o       (rec_pc),
        .rec_instr_o    (rec_instr),
        .rec_npc_o      (rec_npc),
        .rec_reg_o      (rec_reg),
        .rec_gpr_addr_o (rec_gpr_addr),
        .rec_value_o    (rec_value),
        .overflow_o     (overflow)
    );

    always #4 clk = ~clk;  // 8 ns period

    //----------------------------------------
    // Helpers
    //----------------------------------------
    task automatic end_with_failure();
        $display("sim failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_event(input string name, input trace_event_e got,
                               input trace_event_e exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input trace_reg_e got, input trace_reg_e exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    //----------------------------------------
    // Reference model
    //----------------------------------------
    function automatic void predict_entry(input logic [31:0] stamp, input logic [31:0] pc);
        exp_rec_t    r;
        logic [31:0] mip_w;
        logic [31:0] mie_w;
        r.stamp = stamp;
        r.ev    = e_exc_i ? EV_EXC : e_irq_i ? EV_IRQ : e_wake_i ? EV_WAKE : EV_NONE;
        r.pc    = pc;
        r.instr = instr_i;
        r.npc   = pc_update_i;
        r.kind  = REG_NONE;
        r.addr  = '0;
        r.value = '0;
        mip_w = (32'(mip_msip_i) << 3) | (32'(mip_mtip_i) << 7) | (32'(mip_meip_i) << 11);
        mie_w = (32'(mie_msie_i) << 3) | (32'(mie_mtie_i) << 7) | (32'(mie_meie_i) << 11);
        if (r.ev == EV_EXC || r.ev == EV_IRQ) begin
            r.kind  = REG_MSTATUS;
            r.value = 32'h1800 | (32'(mstatus_mpie_i) << 7) | (32'(mstatus_mie_i) << 3);
            exp_q.push_back(r);
            r.kind  = REG_MEPC;
            r.value = {mepc_i, 1'b0};
            exp_q.push_back(r);
            r.kind  = REG_MCAUSE;
            r.value = {mcause_irq_i, 27'd0, mcause_ec_i};
            exp_q.push_back(r);
            r.kind  = REG_MTVAL;
            r.value = mtval_i;
            exp_q.push_back(r);
        end else if (r.ev == EV_WAKE && (mip_w & mie_w) != 32'd0) begin
            r.kind  = REG_MIP;
            r.value = mip_w;
            exp_q.push_back(r);
            r.kind  = REG_MIE;
            r.value = mie_w;
            exp_q.push_back(r);
        end else if (r.ev == EV_NONE && gpr_wr_en_i && gpr_wr_addr_i != 5'd0) begin
            r.kind  = REG_GPR;
            r.addr  = gpr_wr_addr_i;
            r.value = gpr_wr_data_i;
            exp_q.push_back(r);
        end else begin
            exp_q.push_back(r);  // Empty record
        end
    endfunction

    always @(negedge clk) begin
        if (!rst_n) begin
            ref_cycle = '0;
            ref_npc   = '0;
            exp_q.delete();
        end else begin
            if (pc_update_en_i || gpr_wr_en_i) begin
                if (predict_en) begin
                    predict_entry(ref_cycle, ref_npc);
                end
                ref_npc = pc_update_i;
            end
            ref_cycle = ref_cycle + 32'd1;
        end
    end

    // Record checker
    always @(negedge clk) begin
        if (rst_n && check_en) begin
            check_flag("overflow_o", overflow, 1'b0);
            if (rec_valid && exp_q.size() == 0) begin
                $display("A record came out while no record was expected");
                end_with_failure();
            end else if (rec_valid) begin
                front = exp_q.pop_front();
                check_word("rec_stamp_o", rec_stamp, front.stamp);
                check_event("rec_event_o", rec_event, front.ev);
                check_word("rec_pc_o", rec_pc, front.pc);
                check_word("rec_instr_o", rec_instr, front.instr);
                check_word("rec_npc_o", rec_npc, front.npc);
                check_reg("rec_reg_o", rec_reg, front.kind);
                check_word("rec_gpr_addr_o", 32'(rec_gpr_addr), 32'(front.addr));
                check_word("rec_value_o", rec_value, front.value);
            end
        end
    end

    always @(posedge clk) begin
        tb_cycle = tb_cycle + 1;
        if (tb_cycle > TIMEOUT) begin
            $display("Timeout after %0d cycles, the test did not complete", tb_cycle);
            end_with_failure();
        end
    end

    //----------------------------------------
    // Stimulus tasks
    //----------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // wake_mode 1 forces an enabled pending bit, 2 forces none
    task automatic drive_update(input logic pc_en, input logic gpr_en, input logic exc,
                                input logic irq, input logic wake, input int wake_mode);
        logic [2:0] ie;
        logic [2:0] ip;
        logic [4:0] addr;
        int         pick;
        ie = 3'(rand_bits(3));
        ip = 3'(rand_bits(3));
        if (wake_mode == 1) begin
            pick     = int'(rand_bits(2)) % 3;
            ie[pick] = 1'b1;
            ip[pick] = 1'b1;
        end else if (wake_mode == 2) begin
            ie = ~ip;
        end
        addr = 5'(rand_bits(5));
        if (rand_bits(3) == 32'd0) begin
            addr = 5'd0;  // Extra x0 writes
        end
        @(posedge clk);
        pc_update_en_i <= pc_en;
        pc_update_i    <= rand_bits(32);
        instr_i        <= rand_bits(32);
        gpr_wr_en_i    <= gpr_en;
        gpr_wr_addr_i  <= addr;
        gpr_wr_data_i  <= rand_bits(32);
        mstatus_mie_i  <= 1'(rand_bits(1));
        mstatus_mpie_i <= 1'(rand_bits(1));
        mie_meie_i     <= ie[2];
        mie_mtie_i     <= ie[1];
        mie_msie_i     <= ie[0];
        mip_meip_i     <= ip[2];
        mip_mtip_i     <= ip[1];
        mip_msip_i     <= ip[0];
        mepc_i         <= 31'(rand_bits(31));
        mcause_irq_i   <= 1'(rand_bits(1));
        mcause_ec_i    <= 4'(rand_bits(4));
        mtval_i        <= rand_bits(32);
        e_exc_i        <= exc;
        e_irq_i        <= irq;
        e_wake_i       <= wake;
    endtask

    task automatic go_idle();
        @(posedge clk);
        pc_update_en_i <= 1'b0;
        gpr_wr_en_i    <= 1'b0;
        e_exc_i        <= 1'b0;
        e_irq_i        <= 1'b0;
        e_wake_i       <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            check_flag("rec_valid_o", rec_valid, 1'b0);
            check_flag("overflow_o", overflow, 1'b0);
        end
    endtask

    //----------------------------------------
    // Test sequence
    //----------------------------------------
    initial begin
        logic [2:0] ev_bits;
        int         kind;
        int         quiet_run;
        clk            = 1'b0;
        rst_n          = 1'b0;
        pc_update_en_i = 1'b0;
        pc_update_i    = '0;
        instr_i        = '0;
        gpr_wr_en_i    = 1'b0;
        gpr_wr_addr_i  = '0;
        gpr_wr_data_i  = '0;
        mstatus_mie_i  = 1'b0;
        mstatus_mpie_i = 1'b0;
        mie_meie_i     = 1'b0;
        mie_mtie_i     = 1'b0;
        mie_msie_i     = 1'b0;
        mip_meip_i     = 1'b0;
        mip_mtip_i     = 1'b0;
        mip_msip_i     = 1'b0;
        mepc_i         = '0;
        mcause_irq_i   = 1'b0;
        mcause_ec_i    = '0;
        mtval_i        = '0;
        e_exc_i        = 1'b0;
        e_irq_i        = 1'b0;
        e_wake_i       = 1'b0;

        apply_reset();
        check_quiet(QUIET_CYCLES);
        check_en = 1'b1;

        repeat (N_GPR) begin  // Register writes
            drive_update(1'(rand_bits(1)), 1'b1, 1'b0, 1'b0, 1'b0, 0);
            go_idle();
            wait_drained();
        end

        repeat (N_TRAP) begin  // Traps with several events at once
            ev_bits = 3'(rand_bits(3));
            if (ev_bits[1:0] == 2'b00) begin
                ev_bits[0] = 1'b1;
            end
            drive_update(1'b1, 1'(rand_bits(1)), ev_bits[0], ev_bits[1], ev_bits[2], 0);
            go_idle();
            wait_drained();
        end

        for (int i = 0; i < 2 * N_WAKE; i++) begin
            drive_update(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, (i % 2 == 0) ? 1 : 2);
            go_idle();
            wait_drained();
        end

        // Bursts of two or three back-to-back updates
        repeat (N_BURST) begin
            repeat (2 + int'(rand_bits(1))) begin
                kind = int'(rand_bits(2));
                drive_update(1'b1, kind == 0, kind == 1, kind == 2, kind == 3, 0);
            end
            go_idle();
            wait_drained();
        end

        // Records during overflow are not predicted
        predict_en = 1'b0;
        check_en   = 1'b0;
        repeat (OVF_CYCLES) drive_update(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 0);
        go_idle();
        repeat (2) @(negedge clk);
        check_flag("overflow_o", overflow, 1'b1);

        // Entries are one idle cycle apart, two in a row mean the FIFO is empty
        quiet_run = 0;
        while (quiet_run < 2) begin
            @(negedge clk);
            if (rec_valid) begin
                quiet_run = 0;
            end else begin
                quiet_run = quiet_run + 1;
            end
        end
        repeat (OVF_HOLD) begin
            @(negedge clk);
            check_flag("rec_valid_o", rec_valid, 1'b0);
            check_flag("overflow_o", overflow, 1'b1);
        end

        apply_reset();
        predict_en = 1'b1;
        check_quiet(QUIET_CYCLES);
        check_en = 1'b1;
        drive_update(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        go_idle();
        wait_drained();
        repeat (4) @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d expected records never came out", exp_q.size());
            end_with_failure();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule : tb_trace
